//--- dv/baser_rx_checker.sv
// receiver output checker, compares beats, statistics pulses and bad block count
`timescale 1ns/1ps

module baser_rx_checker (
    input logic                   clk,
    input logic                   rst,
    input baser_rx_pkg::rx_beat_t rx_out,
    input baser_rx_pkg::rx_stat_t rx_stat,
    input logic                   stat_bad_block
);

import baser_rx_pkg::*;

rx_beat_t exp_beat_q[$];
rx_stat_t exp_stat_q[$];
int       exp_bad_blocks = 0;
int       bad_blocks = 0;
int       errors = 0;
int       beats_seen = 0;
int       stats_seen = 0;

task automatic add_beat(input rx_beat_t beat);
    exp_beat_q.push_back(beat);
endtask

task automatic add_stat(input rx_stat_t stat);
    exp_stat_q.push_back(stat);
endtask

task automatic add_bad_blocks(input int n);
    exp_bad_blocks += n;
endtask

function automatic int pending();
    return exp_beat_q.size() + exp_stat_q.size();
endfunction

task automatic report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
endtask

task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (pending() > 0 && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (pending() > 0) begin
        errors++;
        $display("timeout after %0d cycles, %0d beats and %0d statistics pulses never arrived",
                 limit, exp_beat_q.size(), exp_stat_q.size());
    end
endtask

task automatic compare_bad_block_count();
    if (bad_blocks != exp_bad_blocks) begin
        report_mismatch("stat_bad_block count", exp_bad_blocks, bad_blocks);
    end
endtask

// outputs change on the rising edge, sampled on the falling edge
always @(negedge clk) begin : beat_compare
    rx_beat_t    exp;
    logic [63:0] mask;
    int          i;
    if (!rst && rx_out.valid) begin
        beats_seen++;
        if (exp_beat_q.size() == 0) begin
            errors++;
            $display("unexpected output beat at t=%0t with data %h", $time, rx_out.data);
        end else begin
            exp = exp_beat_q.pop_front();
            for (i = 0; i < 8; i++) begin
                mask[8*i +: 8] = {8{exp.keep[i]}};
            end
            if (rx_out.keep != exp.keep) begin
                report_mismatch("rx_out.keep", exp.keep, rx_out.keep);
            end
            // bytes outside keep carry FCS or padding
            if ((rx_out.data & mask) != (exp.data & mask)) begin
                report_mismatch("rx_out.data", exp.data & mask, rx_out.data & mask);
            end
            if (rx_out.last != exp.last) begin
                report_mismatch("rx_out.last", exp.last, rx_out.last);
            end
            if (rx_out.user != exp.user) begin
                report_mismatch("rx_out.user", exp.user, rx_out.user);
            end
        end
    end
end

always @(negedge clk) begin : stat_compare
    rx_stat_t exp;
    if (!rst && |rx_stat[8:0]) begin
        stats_seen++;
        if (!(rx_out.valid && rx_out.last)) begin
            errors++;
            $display("statistics pulse at t=%0t without a last beat", $time);
        end
        if (exp_stat_q.size() == 0) begin
            errors++;
            $display("unexpected statistics pulse at t=%0t", $time);
        end else begin
            exp = exp_stat_q.pop_front();
            if (rx_stat.pkt_len != exp.pkt_len) begin
                report_mismatch("rx_stat.pkt_len", exp.pkt_len, rx_stat.pkt_len);
            end
            if (rx_stat[8:0] != exp[8:0]) begin
                report_mismatch("rx_stat flags", exp[8:0], rx_stat[8:0]);
            end
        end
    end
end

always @(negedge clk) begin
    if (!rst && stat_bad_block) begin
        bad_blocks++;
    end
end

endmodule

//--- dv/baser_rx_patterns.txt
# c max_len enable | p word | f payload_bytes fcs_xor abort_after | h header word
# e data keep last user | s pkt_len flags (good..bcast) | b bad_block_pulses
c 05ee 1
# broadcast, terminate lane 2
p 0002ffffffffffff
p 0000000801000000
f 14 0 0
e 0002ffffffffffff ff 0 0
e 0000000801000000 3f 1 0
s 0012 101
# bad header, illegal block type, start in lane 4
h 0 1122334455667788
h 1 0000000000000000
h 1 d555555500000033
b 2
# unicast, terminate lane 6
p 0002554433221100
p adde000802000000
p 000000000000efbe
f 18 0 0
e 0002554433221100 ff 0 0
e adde000802000000 ff 0 0
e 000000000000efbe 03 1 0
s 0016 104
# corrupted FCS
p 0002ffffffffffff
p 0000000801000000
f 14 1 0
e 0002ffffffffffff ff 0 0
e 0000000801000000 3f 1 1
s 0012 0c1
# 22 bytes against a 21 byte limit
c 0015 1
p 0002554433221100
p adde000802000000
p 000000000000efbe
f 18 0 0
e 0002554433221100 ff 0 0
e adde000802000000 ff 0 0
e 000000000000efbe 03 1 1
s 0016 0a4
# idle after two data blocks
p 0002554433221100
p adde000802000000
f 16 0 2
e 0002554433221100 ff 0 0
e adde000802000000 ff 1 1
s 0010 094
# receiver disabled
c 05ee 0
p 0002ffffffffffff
p 0000000801000000
f 14 0 0

//--- dv/tb_baser_rx.sv
// receiver testbench that reads block patterns, drives frames and reports the result
`timescale 1ns/1ps

module tb_baser_rx;

import baser_rx_pkg::*;

localparam pattern_file = "dv/baser_rx_patterns.txt";
localparam int drain_timeout = 400;
localparam logic [31:0] seed_init = 32'h1796;

typedef struct packed {
    logic [7:0]  kind;
    logic [63:0] word;
    logic [15:0] arg0;
    logic [31:0] arg1;
    logic [7:0]  arg2;
} cmd_t;

logic        clk = 1'b0;
logic        rst;
logic [1:0]  rx_hdr;
block_word_t rx_data;
logic [15:0] cfg_max_pkt_len;
logic        cfg_enable;
rx_beat_t    rx_out;
rx_stat_t    rx_stat;
logic        stat_bad_block;

cmd_t        cmd_q[$];
logic [63:0] word_q[$];
logic [7:0]  byte_q[$];
integer      seed;
int          load_errors = 0;

always #2 clk = ~clk;

baser_rx_top dut (
    .clk             (clk),
    .rst             (rst),
    .rx_hdr          (rx_hdr),
    .rx_data         (rx_data),
    .cfg_max_pkt_len (cfg_max_pkt_len),
    .cfg_enable      (cfg_enable),
    .rx_out          (rx_out),
    .rx_stat         (rx_stat),
    .stat_bad_block  (stat_bad_block)
);

baser_rx_checker chk (
    .clk            (clk),
    .rst            (rst),
    .rx_out         (rx_out),
    .rx_stat        (rx_stat),
    .stat_bad_block (stat_bad_block)
);

// reflected ethernet CRC-32 over one byte
function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    int          k;
    c = crc ^ {24'd0, b};
    for (k = 0; k < 8; k++) begin
        c = c[0] ? (c >> 1) ^ 32'hedb88320 : c >> 1;
    end
    return c;
endfunction

function automatic logic [7:0] term_type(input int lane);
    case (lane)
        0: return bt_term_0;
        1: return bt_term_1;
        2: return bt_term_2;
        3: return bt_term_3;
        4: return bt_term_4;
        5: return bt_term_5;
        6: return bt_term_6;
        default: return bt_term_7;
    endcase
endfunction

function automatic int random_gap();
    return 1 + ($unsigned($random(seed)) % 4);
endfunction

task automatic check_fields(input logic [7:0] tag, input integer got, input integer want);
    if (got != want) begin
        load_errors++;
        $display("pattern line '%c' has %0d fields where %0d are needed", tag, got, want);
    end
endtask

task automatic drive_block(input logic [1:0] hdr, input logic [63:0] word);
    @(posedge clk);
    #0.5;
    rx_hdr = hdr;
    rx_data = word;
endtask

task automatic drive_idle(input int n);
    repeat (n) drive_block(sync_ctrl, 64'h1e);
endtask

// sends start and data blocks and ends with a terminate unless aborted after abort blocks
task automatic send_frame(input int nbytes, input logic [31:0] fcs_xor, input int abort);
    logic [31:0] crc;
    logic [63:0] word;
    int          nblk;
    int          lane;
    int          i;
    byte_q.delete();
    crc = 32'hffffffff;
    for (i = 0; i < nbytes; i++) begin
        word = word_q[i / 8];
        byte_q.push_back(word[8 * (i % 8) +: 8]);
        crc = crc_byte(crc, word[8 * (i % 8) +: 8]);
    end
    crc = ~crc ^ fcs_xor;
    for (i = 0; i < 4; i++) begin
        byte_q.push_back(crc[8*i +: 8]);
    end
    word_q.delete();
    // six preamble bytes and the SFD above block type 78
    drive_block(sync_ctrl, 64'hd555555555555578);
    nblk = 0;
    while (byte_q.size() >= 8 && (abort == 0 || nblk < abort)) begin
        for (i = 0; i < 8; i++) begin
            word[8*i +: 8] = byte_q.pop_front();
        end
        drive_block(sync_data, word);
        nblk++;
    end
    if (abort == 0) begin
        lane = byte_q.size();
        word = '0;
        for (i = 0; i < lane; i++) begin
            word[8*(i+1) +: 8] = byte_q[i];
        end
        word[7:0] = term_type(lane);
        drive_block(sync_ctrl, word);
    end
endtask

task automatic load_patterns();
    integer           fd;
    integer           r;
    logic [7:0]       tag;
    logic [63:0]      v0, v1, v2, v3;
    logic [8*100-1:0] skip;
    cmd_t             cmd;
    rx_beat_t         beat;
    fd = $fopen(pattern_file, "r");
    if (fd == 0) begin
        load_errors++;
        $display("cannot open pattern file %s", pattern_file);
    end else begin
        while ($fscanf(fd, " %c", tag) == 1) begin
            cmd = '0;
            cmd.kind = tag;
            case (tag)
                "#": r = $fgets(skip, fd);
                "c": begin
                    r = $fscanf(fd, "%h %h", v0, v1);
                    check_fields(tag, r, 2);
                    cmd.arg0 = v0[15:0];
                    cmd.arg2 = v1[7:0];
                    cmd_q.push_back(cmd);
                end
                "p": begin
                    r = $fscanf(fd, "%h", v0);
                    check_fields(tag, r, 1);
                    cmd.word = v0;
                    cmd_q.push_back(cmd);
                end
                "f": begin
                    r = $fscanf(fd, "%d %h %d", v0, v1, v2);
                    check_fields(tag, r, 3);
                    cmd.arg0 = v0[15:0];
                    cmd.arg1 = v1[31:0];
                    cmd.arg2 = v2[7:0];
                    cmd_q.push_back(cmd);
                end
                "h": begin
                    r = $fscanf(fd, "%h %h", v0, v1);
                    check_fields(tag, r, 2);
                    cmd.arg2 = v0[7:0];
                    cmd.word = v1;
                    cmd_q.push_back(cmd);
                end
                "e": begin
                    r = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
                    check_fields(tag, r, 4);
                    beat = '0;
                    beat.data = v0;
                    beat.keep = v1[7:0];
                    beat.valid = 1'b1;
                    beat.last = v2[0];
                    beat.user = v3[0];
                    chk.add_beat(beat);
                end
                "s": begin
                    r = $fscanf(fd, "%h %h", v0, v1);
                    check_fields(tag, r, 2);
                    // good is the top flag bit and bcast is bit 0
                    chk.add_stat({v0[15:0], v1[8:0]});
                end
                "b": begin
                    r = $fscanf(fd, "%d", v0);
                    check_fields(tag, r, 1);
                    chk.add_bad_blocks(v0);
                end
                default: begin
                    load_errors++;
                    $display("unknown line tag '%c' in pattern file", tag);
                end
            endcase
        end
        $fclose(fd);
    end
endtask

task automatic run_commands();
    cmd_t cmd;
    while (cmd_q.size() > 0) begin
        cmd = cmd_q.pop_front();
        case (cmd.kind)
            "c": begin
                // let the previous frame leave the pipeline first
                drive_idle(8);
                cfg_max_pkt_len = cmd.arg0;
                cfg_enable = cmd.arg2[0];
            end
            "p": word_q.push_back(cmd.word);
            "h": begin
                drive_idle(random_gap());
                drive_block(cmd.arg2[1:0], cmd.word);
            end
            "f": begin
                drive_idle(random_gap());
                send_frame(cmd.arg0, cmd.arg1, cmd.arg2);
            end
            default: ;
        endcase
    end
    drive_idle(1);
endtask

initial begin
    seed = seed_init;
    rst = 1'b1;
    rx_hdr = sync_ctrl;
    rx_data = 64'h1e;
    cfg_max_pkt_len = 16'd1518;
    cfg_enable = 1'b1;
    load_patterns();
    repeat (2) @(posedge clk);
    #0.5;
    rst = 1'b0;
    run_commands();
    chk.wait_drained(drain_timeout);
    repeat (16) @(posedge clk);
    chk.compare_bad_block_count();
    $display("errors %0d, beats %0d, statistics pulses %0d, bad blocks %0d",
             chk.errors + load_errors, chk.beats_seen, chk.stats_seen, chk.bad_blocks);
    if (chk.errors + load_errors == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

//--- rtl/baser_block_decoder.sv
// 66-bit block decoder that finds start and terminate blocks and checks framing
`timescale 1ns/1ps

module baser_block_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [1:0]                rx_hdr,
    input  baser_rx_pkg::block_word_t rx_data,
    output baser_rx_pkg::dec_word_t   dec,
    output logic                      stat_bad_block
);

import baser_rx_pkg::*;

dec_word_t  cur;
dec_word_t  d0;
logic       bad;
logic       frame_reg;
logic       frame_next;
logic [7:0] btype;

assign btype = rx_data.ctrl.btype;

always_comb begin
    cur = '0;
    cur.data = rx_data.bytes;
    bad = 1'b0;
    frame_next = frame_reg;

    if (rx_hdr == sync_data) begin
        cur.frame_err = !frame_reg;
    end else if (rx_hdr == sync_ctrl) begin
        // any control block closes the frame unless it is a start
        frame_next = 1'b0;
        cur.frame_err = frame_reg;
        case (btype)
            bt_start_0: begin
                cur.start = 1'b1;
                frame_next = 1'b1;
            end
            bt_start_4, bt_os_start: begin
                // opens the line frame but carries no payload
                frame_next = 1'b1;
            end
            bt_ctrl, bt_os_4, bt_os_04, bt_os_0: begin
                // idle and ordered sets are legal blocks
            end
            bt_term_0, bt_term_1, bt_term_2, bt_term_3,
            bt_term_4, bt_term_5, bt_term_6, bt_term_7: begin
                cur.term = 1'b1;
                cur.term_lane = btype[6:4];
                cur.frame_err = !frame_reg;
                // data bytes move down to lane 0 with zeros above
                cur.data = {8'd0, rx_data.ctrl.body}
                    & ({data_w{1'b1}} >> {4'd8 - {1'b0, btype[6:4]}, 3'b000});
            end
            default: begin
                bad = 1'b1;
            end
        endcase
    end else begin
        // bad sync header
        bad = 1'b1;
        frame_next = 1'b0;
        cur.frame_err = frame_reg;
    end
end

always_ff @(posedge clk) begin
    d0 <= cur;
    dec <= d0;
    frame_reg <= frame_next;
    stat_bad_block <= bad;

    if (rst) begin
        d0.start <= 1'b0;
        d0.term <= 1'b0;
        d0.frame_err <= 1'b0;
        dec.start <= 1'b0;
        dec.term <= 1'b0;
        dec.frame_err <= 1'b0;
        frame_reg <= 1'b0;
        stat_bad_block <= 1'b0;
    end
end

endmodule

//--- rtl/baser_crc_check.sv
// running CRC-32 over decoded words with residue match per terminate lane
`timescale 1ns/1ps

module baser_crc_check (
    input  logic                    clk,
    input  logic                    rst,
    input  baser_rx_pkg::dec_word_t dec,
    output logic [4:0]              crc_ok,
    output logic [2:0]              crc_ok_d
);

import baser_rx_pkg::*;

logic [31:0] crc_state;
logic [31:0] crc_next;

// reflected Galois step, lane 0 bit 0 goes first
function automatic logic [31:0] crc_step(
    input logic [31:0]       state,
    input logic [data_w-1:0] data
);
    logic [31:0] s;
    logic        fb;
    s = state;
    for (int i = 0; i < data_w; i++) begin
        fb = s[0] ^ data[i];
        s = s >> 1;
        if (fb) begin
            s = s ^ crc_poly;
        end
    end
    return s;
endfunction

assign crc_next = crc_step(crc_state, dec.data);

// lane 0 terminate means the FCS ended with the previous word
assign crc_ok[0] = crc_state == crc_residue[7];
assign crc_ok[1] = crc_next == crc_residue[0];
assign crc_ok[2] = crc_next == crc_residue[1];
assign crc_ok[3] = crc_next == crc_residue[2];
assign crc_ok[4] = crc_next == crc_residue[3];

always_ff @(posedge clk) begin
    if (dec.start) begin
        crc_state <= crc_init;
    end else begin
        crc_state <= crc_next;
    end

    // lanes 5 to 7, used while the last beat goes out
    crc_ok_d[0] <= crc_next == crc_residue[4];
    crc_ok_d[1] <= crc_next == crc_residue[5];
    crc_ok_d[2] <= crc_next == crc_residue[6];

    if (rst) begin
        crc_state <= crc_init;
        crc_ok_d <= '0;
    end
end

endmodule

//--- rtl/baser_frame_fsm.sv
// frame state machine, builds output beats, checks length and raises statistics
`timescale 1ns/1ps

module baser_frame_fsm (
    input  logic                                 clk,
    input  logic                                 rst,
    input  baser_rx_pkg::dec_word_t              dec,
    input  logic [4:0]                           crc_ok,
    input  logic [2:0]                           crc_ok_d,
    input  logic [baser_rx_pkg::max_len_w-1:0]   cfg_max_pkt_len,
    input  logic                                 cfg_enable,
    output baser_rx_pkg::rx_beat_t               rx_out,
    output baser_rx_pkg::rx_stat_t               rx_stat
);

import baser_rx_pkg::*;

typedef enum logic [1:0] {
    st_idle,
    st_payload,
    st_last
} state_t;

state_t               state, state_next;
logic                 hold_vld, hold_next;
logic [data_w-1:0]    prev_data, prev_next;
logic [max_len_w-1:0] len, len_next;
logic [2:0]           last_lane, lane_next;
logic                 pre_ok, pre_next;
logic                 is_mcast, mc_next;
logic                 is_bcast, bc_next;
rx_beat_t             beat_next;
rx_stat_t             stat_next;

logic                 fin;
logic                 fin_crc;
logic                 fin_ferr;
logic [max_len_w-1:0] fin_len;
logic                 over;
logic                 good;

always_comb begin
    state_next = state;
    hold_next = hold_vld;
    prev_next = prev_data;
    len_next = len;
    lane_next = last_lane;
    pre_next = pre_ok;
    mc_next = is_mcast;
    bc_next = is_bcast;
    beat_next = '0;
    beat_next.data = prev_data;
    beat_next.keep = {keep_w{1'b1}};
    stat_next = '0;
    fin = 1'b0;
    fin_crc = 1'b0;
    fin_ferr = 1'b0;
    fin_len = len;

    case (state)
        st_payload: begin
            if (dec.frame_err) begin
                beat_next.valid = 1'b1;
                beat_next.last = 1'b1;
                fin = 1'b1;
                fin_ferr = 1'b1;
                state_next = st_idle;
            end else if (dec.term && dec.term_lane <= 3'd4) begin
                // held word is the last one, FCS tail trimmed
                beat_next.valid = 1'b1;
                beat_next.last = 1'b1;
                beat_next.keep = 8'hff >> (4'd4 - {1'b0, dec.term_lane});
                fin = 1'b1;
                fin_len = len + max_len_w'(dec.term_lane);
                fin_crc = crc_ok[dec.term_lane];
                state_next = st_idle;
            end else begin
                beat_next.valid = hold_vld;
                prev_next = dec.data;
                hold_next = 1'b1;
                if (!hold_vld) begin
                    mc_next = dec.data[0];
                    bc_next = &dec.data[47:0];
                end
                if (dec.term) begin
                    len_next = len + max_len_w'(dec.term_lane);
                    lane_next = dec.term_lane;
                    state_next = st_last;
                end else if (&len[max_len_w-1:3]) begin
                    len_next = '1;
                end else begin
                    len_next = len + max_len_w'(keep_w);
                end
            end
        end
        st_last: begin
            beat_next.valid = 1'b1;
            beat_next.last = 1'b1;
            beat_next.keep = 8'hff >> (4'd12 - {1'b0, last_lane});
            fin = 1'b1;
            fin_crc = crc_ok_d[2'(last_lane - 3'd5)];
            state_next = st_idle;
        end
        default: begin
            state_next = st_idle;
        end
    endcase

    over = fin_len > cfg_max_pkt_len;
    good = !fin_ferr && fin_crc && !over;

    if (fin) begin
        beat_next.user = !good;
        stat_next.pkt_len = fin_len;
        stat_next.good = good;
        stat_next.bad = !good;
        stat_next.bad_fcs = !fin_ferr && !fin_crc;
        stat_next.oversize = over;
        stat_next.framing = fin_ferr;
        stat_next.preamble = !pre_ok;
        stat_next.ucast = !is_mcast;
        stat_next.mcast = is_mcast && !is_bcast;
        stat_next.bcast = is_bcast;
    end

    // a start can follow a closing beat directly
    if (state_next == st_idle && dec.start && cfg_enable) begin
        state_next = st_payload;
        hold_next = 1'b0;
        len_next = '0;
        pre_next = dec.data[63:8] == eth_preamble;
    end
end

always_ff @(posedge clk) begin
    state <= state_next;
    hold_vld <= hold_next;
    prev_data <= prev_next;
    len <= len_next;
    last_lane <= lane_next;
    pre_ok <= pre_next;
    is_mcast <= mc_next;
    is_bcast <= bc_next;
    rx_out <= beat_next;
    rx_stat <= stat_next;

    if (rst) begin
        state <= st_idle;
        hold_vld <= 1'b0;
        rx_out.valid <= 1'b0;
        rx_out.last <= 1'b0;
        rx_out.user <= 1'b0;
        rx_stat <= '0;
    end
end

endmodule

//--- rtl/baser_rx_pkg.sv
// 10GBASE-R receive package with block codes, CRC constants and stream types
package baser_rx_pkg;

localparam int data_w = 64;
localparam int keep_w = 8;
localparam int max_len_w = 16;

localparam logic [1:0] sync_data = 2'b10;
localparam logic [1:0] sync_ctrl = 2'b01;

// legal block type bytes
localparam logic [7:0] bt_ctrl     = 8'h1e;
localparam logic [7:0] bt_os_4     = 8'h2d;
localparam logic [7:0] bt_start_4  = 8'h33;
localparam logic [7:0] bt_os_start = 8'h66;
localparam logic [7:0] bt_os_04    = 8'h55;
localparam logic [7:0] bt_start_0  = 8'h78;
localparam logic [7:0] bt_os_0     = 8'h4b;
localparam logic [7:0] bt_term_0   = 8'h87;
localparam logic [7:0] bt_term_1   = 8'h99;
localparam logic [7:0] bt_term_2   = 8'haa;
localparam logic [7:0] bt_term_3   = 8'hb4;
localparam logic [7:0] bt_term_4   = 8'hcc;
localparam logic [7:0] bt_term_5   = 8'hd2;
localparam logic [7:0] bt_term_6   = 8'he1;
localparam logic [7:0] bt_term_7   = 8'hff;

// reflected form of 0x04c11db7
localparam logic [31:0] crc_poly = 32'hedb88320;
localparam logic [31:0] crc_init = 32'hffffffff;

// state after a good FCS, index is the FCS end byte within the word
localparam logic [7:0][31:0] crc_residue = {
    ~32'h2144df1c, ~32'hc622f71d, ~32'hb1c2a1a3, ~32'h9d6cdf7e,
    ~32'h6522df69, ~32'he60914ae, ~32'he38a6876, ~32'h6b87b1ec
};

// bytes 1 to 7 of a lane 0 start block
localparam logic [55:0] eth_preamble = 56'hd5555555555555;

typedef struct packed {
    logic [55:0] body;
    logic [7:0]  btype;
} ctrl_view_t;

// one 64-bit block payload, read as data bytes or as a control block
typedef union packed {
    logic [7:0][7:0] bytes;
    ctrl_view_t      ctrl;
} block_word_t;

typedef struct packed {
    logic [data_w-1:0] data;
    logic              start;
    logic              term;
    logic [2:0]        term_lane;
    logic              frame_err;
} dec_word_t;

typedef struct packed {
    logic [data_w-1:0] data;
    logic [keep_w-1:0] keep;
    logic              valid;
    logic              last;
    logic              user;
} rx_beat_t;

typedef struct packed {
    logic [max_len_w-1:0] pkt_len;
    logic                 good;
    logic                 bad;
    logic                 bad_fcs;
    logic                 oversize;
    logic                 framing;
    logic                 preamble;
    logic                 ucast;
    logic                 mcast;
    logic                 bcast;
} rx_stat_t;

endpackage

//--- rtl/baser_rx_top.sv
// 10GBASE-R frame receiver top, block decode, CRC check and framing
`timescale 1ns/1ps

module baser_rx_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [1:0]                            rx_hdr,
    input  baser_rx_pkg::block_word_t             rx_data,
    input  logic [baser_rx_pkg::max_len_w-1:0]    cfg_max_pkt_len,
    input  logic                                  cfg_enable,
    output baser_rx_pkg::rx_beat_t                rx_out,
    output baser_rx_pkg::rx_stat_t                rx_stat,
    output logic                                  stat_bad_block
);

import baser_rx_pkg::*;

dec_word_t  dec;
logic [4:0] crc_ok;
logic [2:0] crc_ok_d;

baser_block_decoder u_decoder (
    .clk            (clk),
    .rst            (rst),
    .rx_hdr         (rx_hdr),
    .rx_data        (rx_data),
    .dec            (dec),
    .stat_bad_block (stat_bad_block)
);

baser_crc_check u_crc (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .crc_ok   (crc_ok),
    .crc_ok_d (crc_ok_d)
);

baser_frame_fsm u_fsm (
    .clk             (clk),
    .rst             (rst),
    .dec             (dec),
    .crc_ok          (crc_ok),
    .crc_ok_d        (crc_ok_d),
    .cfg_max_pkt_len (cfg_max_pkt_len),
    .cfg_enable      (cfg_enable),
    .rx_out          (rx_out),
    .rx_stat         (rx_stat)
);

endmodule

//--- src.f
rtl/baser_rx_pkg.sv
rtl/baser_block_decoder.sv
rtl/baser_crc_check.sv
rtl/baser_frame_fsm.sv
rtl/baser_rx_top.sv
dv/baser_rx_checker.sv
dv/tb_baser_rx.sv
